/* source/aluOpPkg.sv */
package aluOpPkg;

  localparam int DataWidth = 32;

  // command codes 0 to 7
  localparam int CmdWidth = 3;

  localparam logic [CmdWidth-1:0] CmdAdd  = 3'd0;
  localparam logic [CmdWidth-1:0] CmdSub  = 3'd1;
  localparam logic [CmdWidth-1:0] CmdXor  = 3'd2;
  localparam logic [CmdWidth-1:0] CmdSlt  = 3'd3;
  localparam logic [CmdWidth-1:0] CmdAnd  = 3'd4;
  localparam logic [CmdWidth-1:0] CmdNand = 3'd5;
  localparam logic [CmdWidth-1:0] CmdNor  = 3'd6;
  localparam logic [CmdWidth-1:0] CmdOr   = 3'd7;

  // which functional unit drives the result
  localparam int SelWidth = 3;

  localparam logic [SelWidth-1:0] SelAddSub = 3'd0;
  localparam logic [SelWidth-1:0] SelXor    = 3'd1;
  localparam logic [SelWidth-1:0] SelSlt    = 3'd2;
  localparam logic [SelWidth-1:0] SelAnd    = 3'd3; // and / nand
  localparam logic [SelWidth-1:0] SelOr     = 3'd4; // or / nor

endpackage

/* source/aluFlowPkg.sv */
package aluFlowPkg;

  // result queue entries and the producer's starting credit count
  localparam int QueueDepth = 4;

  // slots the consumer grants after reset
  localparam int ResultCredits = 2;

  // read/write pointers carry one extra wrap bit to tell full from empty
  localparam int QueuePtrWidth = $clog2(QueueDepth) + 1;

  localparam int CreditWidth = $clog2(ResultCredits + 1);

endpackage

/* source/aluDecode.sv */
`timescale 1ns/1ps

module aluDecode (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           opValid,
  input  logic [aluOpPkg::CmdWidth-1:0]  command,
  input  logic [aluOpPkg::DataWidth-1:0] operandA,
  input  logic [aluOpPkg::DataWidth-1:0] operandB,
  output logic                           decValid,
  output logic [aluOpPkg::DataWidth-1:0] decOperandA,
  output logic [aluOpPkg::DataWidth-1:0] decOperandB,
  output logic [aluOpPkg::SelWidth-1:0]  decSelect,
  output logic                           decSubtract,
  output logic                           decInvert
);

  logic [aluOpPkg::SelWidth-1:0] selectNext;
  logic                          subtractNext;
  logic                          invertNext;

  // control table
  always_comb begin
    selectNext   = aluOpPkg::SelAddSub;
    subtractNext = 1'b0;
    invertNext   = 1'b0;
    case (command)
      aluOpPkg::CmdAdd:  selectNext = aluOpPkg::SelAddSub;
      aluOpPkg::CmdSub:  subtractNext = 1'b1;
      aluOpPkg::CmdXor:  selectNext = aluOpPkg::SelXor;
      aluOpPkg::CmdSlt: begin
        selectNext   = aluOpPkg::SelSlt;
        subtractNext = 1'b1; // slt needs a - b
      end
      aluOpPkg::CmdAnd:  selectNext = aluOpPkg::SelAnd;
      aluOpPkg::CmdNand: begin
        selectNext = aluOpPkg::SelAnd;
        invertNext = 1'b1;
      end
      aluOpPkg::CmdNor: begin
        selectNext = aluOpPkg::SelOr;
        invertNext = 1'b1;
      end
      aluOpPkg::CmdOr:   selectNext = aluOpPkg::SelOr;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) decValid <= 1'b0;
    else       decValid <= opValid;
  end

  // payload only loads with a valid op
  always_ff @(posedge clk) begin
    if (opValid) begin
      decOperandA <= operandA;
      decOperandB <= operandB;
      decSelect   <= selectNext;
      decSubtract <= subtractNext;
      decInvert   <= invertNext;
    end
  end

endmodule

/* source/aluExecute.sv */
`timescale 1ns/1ps

module aluExecute (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           decValid,
  input  logic [aluOpPkg::DataWidth-1:0] decOperandA,
  input  logic [aluOpPkg::DataWidth-1:0] decOperandB,
  input  logic [aluOpPkg::SelWidth-1:0]  decSelect,
  input  logic                           decSubtract,
  input  logic                           decInvert,
  output logic                           exeValid,
  output logic [aluOpPkg::DataWidth-1:0] exeResult,
  output logic                           exeCarryout,
  output logic                           exeZero,
  output logic                           exeOverflow
);

  localparam int Msb = aluOpPkg::DataWidth - 1;

  logic [aluOpPkg::DataWidth-1:0] operandBEff;
  logic [aluOpPkg::DataWidth:0]   sumFull;
  logic [aluOpPkg::DataWidth-1:0] sum;
  logic                           sumCarry;
  logic                           sumOverflow;
  logic                           sumZero;
  logic                           lessThan;

  logic [aluOpPkg::DataWidth-1:0] xorRes;
  logic [aluOpPkg::DataWidth-1:0] andRes;
  logic [aluOpPkg::DataWidth-1:0] orRes;
  logic [aluOpPkg::DataWidth-1:0] invMask;

  logic [aluOpPkg::DataWidth-1:0] resultNext;
  logic                           carryNext;
  logic                           zeroNext;
  logic                           overflowNext;

  // subtract is a + ~b + 1
  assign operandBEff = decSubtract ? ~decOperandB : decOperandB;
  assign sumFull     = {1'b0, decOperandA} + {1'b0, operandBEff}
                     + {{aluOpPkg::DataWidth{1'b0}}, decSubtract};
  assign sum         = sumFull[Msb:0];
  assign sumCarry    = sumFull[aluOpPkg::DataWidth];

  // operands agree in sign but the sum does not
  assign sumOverflow = (decOperandA[Msb] == operandBEff[Msb]) && (sum[Msb] != decOperandA[Msb]);
  assign sumZero     = (sum == '0);

  // sign of a - b, corrected when the difference overflowed
  assign lessThan = sum[Msb] ^ sumOverflow;

  assign invMask = {aluOpPkg::DataWidth{decInvert}};
  assign xorRes  = decOperandA ^ decOperandB;
  assign andRes  = (decOperandA & decOperandB) ^ invMask; // nand when inverted
  assign orRes   = (decOperandA | decOperandB) ^ invMask; // nor when inverted

  always_comb begin
    resultNext   = sum;
    carryNext    = 1'b0;
    zeroNext     = 1'b0;
    overflowNext = 1'b0;
    case (decSelect)
      aluOpPkg::SelAddSub: begin
        resultNext   = sum;
        carryNext    = sumCarry;
        zeroNext     = sumZero;
        overflowNext = sumOverflow;
      end
      aluOpPkg::SelXor: resultNext = xorRes;
      aluOpPkg::SelSlt: resultNext = {{(aluOpPkg::DataWidth-1){1'b0}}, lessThan};
      aluOpPkg::SelAnd: resultNext = andRes;
      aluOpPkg::SelOr:  resultNext = orRes;
      default:          resultNext = sum;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) exeValid <= 1'b0;
    else       exeValid <= decValid;
  end

  always_ff @(posedge clk) begin
    if (decValid) begin
      exeResult   <= resultNext;
      exeCarryout <= carryNext;
      exeZero     <= zeroNext;
      exeOverflow <= overflowNext;
    end
  end

endmodule

/* source/resultQueue.sv */
`timescale 1ns/1ps

module resultQueue (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           exeValid,
  input  logic [aluOpPkg::DataWidth-1:0] exeResult,
  input  logic                           exeCarryout,
  input  logic                           exeZero,
  input  logic                           exeOverflow,
  input  logic                           resCredit,
  output logic                           resValid,
  output logic [aluOpPkg::DataWidth-1:0] result,
  output logic                           carryout,
  output logic                           zero,
  output logic                           overflow,
  output logic                           opCredit
);

  localparam int IdxWidth = aluFlowPkg::QueuePtrWidth - 1;

  logic [aluOpPkg::DataWidth-1:0] resultMem [aluFlowPkg::QueueDepth];
  logic                           carryMem [aluFlowPkg::QueueDepth];
  logic                           zeroMem [aluFlowPkg::QueueDepth];
  logic                           overflowMem [aluFlowPkg::QueueDepth];

  logic [aluFlowPkg::QueuePtrWidth-1:0] wrPtr;
  logic [aluFlowPkg::QueuePtrWidth-1:0] rdPtr;
  logic [aluFlowPkg::CreditWidth-1:0]   outCredits;

  logic [IdxWidth-1:0] wrIdx;
  logic [IdxWidth-1:0] rdIdx;
  logic                notEmpty;
  logic                issue;

  assign wrIdx    = wrPtr[IdxWidth-1:0];
  assign rdIdx    = rdPtr[IdxWidth-1:0];
  assign notEmpty = (wrPtr != rdPtr);

  // head leaves only when the consumer has a free slot
  assign issue = notEmpty && (outCredits != '0);

  // input credits keep the producer within QueueDepth
  always_ff @(posedge clk) begin
    if (exeValid) begin
      resultMem[wrIdx]   <= exeResult;
      carryMem[wrIdx]    <= exeCarryout;
      zeroMem[wrIdx]     <= exeZero;
      overflowMem[wrIdx] <= exeOverflow;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (exeValid) wrPtr <= wrPtr + 1'b1;
      if (issue)    rdPtr <= rdPtr + 1'b1;
    end
  end

  // spend one on issue and get one back per resCredit pulse
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) outCredits <= aluFlowPkg::CreditWidth'(aluFlowPkg::ResultCredits);
    else       outCredits <= outCredits + aluFlowPkg::CreditWidth'(resCredit)
                             - aluFlowPkg::CreditWidth'(issue);
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resValid <= 1'b0;
      opCredit <= 1'b0;
    end else begin
      resValid <= issue;
      opCredit <= resValid; // slot is back in the cycle after the result left
    end
  end

  // registered head entry
  always_ff @(posedge clk) begin
    if (issue) begin
      result   <= resultMem[rdIdx];
      carryout <= carryMem[rdIdx];
      zero     <= zeroMem[rdIdx];
      overflow <= overflowMem[rdIdx];
    end
  end

endmodule

/* source/pipelinedAlu.sv */
`timescale 1ns/1ps

module pipelinedAlu (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           opValid,
  input  logic [aluOpPkg::CmdWidth-1:0]  command,
  input  logic [aluOpPkg::DataWidth-1:0] operandA,
  input  logic [aluOpPkg::DataWidth-1:0] operandB,
  output logic                           opCredit,
  output logic                           resValid,
  output logic [aluOpPkg::DataWidth-1:0] result,
  output logic                           carryout,
  output logic                           zero,
  output logic                           overflow,
  input  logic                           resCredit
);

  // decode to execute
  logic                           decValid;
  logic [aluOpPkg::DataWidth-1:0] decOperandA;
  logic [aluOpPkg::DataWidth-1:0] decOperandB;
  logic [aluOpPkg::SelWidth-1:0]  decSelect;
  logic                           decSubtract;
  logic                           decInvert;

  // execute to queue
  logic                           exeValid;
  logic [aluOpPkg::DataWidth-1:0] exeResult;
  logic                           exeCarryout;
  logic                           exeZero;
  logic                           exeOverflow;

  aluDecode u_aluDecode (
    .clk(clk), .rstN(rstN),
    .opValid(opValid), .command(command),
    .operandA(operandA), .operandB(operandB),
    .decValid(decValid), .decOperandA(decOperandA), .decOperandB(decOperandB),
    .decSelect(decSelect), .decSubtract(decSubtract), .decInvert(decInvert)
  );

  aluExecute u_aluExecute (
    .clk(clk), .rstN(rstN),
    .decValid(decValid), .decOperandA(decOperandA), .decOperandB(decOperandB),
    .decSelect(decSelect), .decSubtract(decSubtract), .decInvert(decInvert),
    .exeValid(exeValid), .exeResult(exeResult), .exeCarryout(exeCarryout),
    .exeZero(exeZero), .exeOverflow(exeOverflow)
  );

  resultQueue u_resultQueue (
    .clk(clk), .rstN(rstN),
    .exeValid(exeValid), .exeResult(exeResult), .exeCarryout(exeCarryout),
    .exeZero(exeZero), .exeOverflow(exeOverflow),
    .resCredit(resCredit),
    .resValid(resValid), .result(result),
    .carryout(carryout), .zero(zero), .overflow(overflow),
    .opCredit(opCredit)
  );

endmodule

/* verification/aluChecker.sv */
`timescale 1ns/1ps

module aluChecker #(
  parameter int NumRows = 1
) (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           opValid,
  input  logic                           opCredit,
  input  logic                           resValid,
  input  logic [aluOpPkg::DataWidth-1:0] result,
  input  logic                           carryout,
  input  logic                           zero,
  input  logic                           overflow,
  input  logic                           resCredit,
  input  logic [aluOpPkg::CmdWidth-1:0]  expCommand,
  input  logic [aluOpPkg::DataWidth-1:0] expResult,
  input  logic                           expCarryout,
  input  logic                           expZero,
  input  logic                           expOverflow,
  input  logic                           endOfTest,
  output int                             rowsDone,
  output int                             errorCount,
  output logic                           reportDone
);

  int   resCount;
  int   grantCount;    // output credits the consumer has handed out
  int   opCreditCount;
  logic opSeen;

  function automatic string cmdName(input logic [aluOpPkg::CmdWidth-1:0] cmd);
    case (cmd)
      aluOpPkg::CmdAdd:  return "add";
      aluOpPkg::CmdSub:  return "sub";
      aluOpPkg::CmdXor:  return "xor";
      aluOpPkg::CmdSlt:  return "slt";
      aluOpPkg::CmdAnd:  return "and";
      aluOpPkg::CmdNand: return "nand";
      aluOpPkg::CmdNor:  return "nor";
      default:           return "or";
    endcase
  endfunction

  function automatic int reportMismatch(input string name,
                                        input logic [aluOpPkg::DataWidth-1:0] expVal,
                                        input logic [aluOpPkg::DataWidth-1:0] actVal);
    if (actVal !== expVal) begin
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, expVal, actVal);
      return 1;
    end
    return 0;
  endfunction

  initial begin
    rowsDone      = 0;
    errorCount    = 0;
    reportDone    = 1'b0;
    resCount      = 0;
    grantCount    = aluFlowPkg::ResultCredits;
    opCreditCount = 0;
    opSeen        = 1'b0;
  end

  always @(posedge clk) begin : sample
    int rowErrors;
    rowErrors = 0;
    // nothing may come out before an op has gone in
    if ((rstN !== 1'b1 || !opSeen) && (resValid === 1'b1 || opCredit === 1'b1)) begin
      $display("resValid or opCredit went high before the first op was accepted, at %0t",
               $time);
      errorCount++;
    end
    if (rstN === 1'b1) begin
      if (opValid === 1'b1) opSeen = 1'b1;
      if (resCredit === 1'b1) grantCount++;
      if (opCredit === 1'b1) opCreditCount++;
      if (resValid === 1'b1) begin
        resCount++;
        if (resCount > grantCount) begin
          $display("result %0d came out with only %0d output credits granted, at %0t",
                   resCount, grantCount, $time);
          errorCount++;
        end
        if (rowsDone >= NumRows) begin
          $display("an extra result %0h arrived after all rows were checked, at %0t",
                   result, $time);
          errorCount++;
        end else begin
          rowErrors += reportMismatch("result", expResult, result);
          rowErrors += reportMismatch("carryout", 32'(expCarryout), 32'(carryout));
          rowErrors += reportMismatch("zero", 32'(expZero), 32'(zero));
          rowErrors += reportMismatch("overflow", 32'(expOverflow), 32'(overflow));
          $display("row %0d %s: %s", rowsDone, cmdName(expCommand),
                   (rowErrors == 0) ? "ok" : "mismatch");
          errorCount += rowErrors;
          rowsDone++;
        end
      end
      if (endOfTest === 1'b1 && !reportDone) begin
        if (opCreditCount != resCount) begin
          $display("%0d opCredit pulses for %0d results delivered", opCreditCount, resCount);
          errorCount++;
        end
        $display("rows %0d/%0d, results %0d, output credits %0d, opCredit pulses %0d, errors %0d",
                 rowsDone, NumRows, resCount, grantCount, opCreditCount, errorCount);
        reportDone = 1'b1;
      end
    end
  end

endmodule

/* verification/pipelinedAluTb.sv */
`timescale 1ns/1ps

module pipelinedAluTb;

  localparam int NumRows       = 24;
  localparam int HoldAfter     = 6;  // results seen before the consumer stalls
  localparam int HoldCycles    = 20;
  localparam int DrainCycles   = 10; // room for stray extra results
  localparam int TimeoutCycles = NumRows * 12 + 100;

  logic                           clk;
  logic                           rstN;
  logic                           opValid;
  logic [aluOpPkg::CmdWidth-1:0]  command;
  logic [aluOpPkg::DataWidth-1:0] operandA;
  logic [aluOpPkg::DataWidth-1:0] operandB;
  logic                           opCredit;
  logic                           resValid;
  logic [aluOpPkg::DataWidth-1:0] result;
  logic                           carryout;
  logic                           zero;
  logic                           overflow;
  logic                           resCredit;

  // stimulus and expected values, one row per op
  logic [aluOpPkg::CmdWidth-1:0]  cmdTab [NumRows];
  logic [aluOpPkg::DataWidth-1:0] aTab [NumRows];
  logic [aluOpPkg::DataWidth-1:0] bTab [NumRows];
  logic [aluOpPkg::DataWidth-1:0] resTab [NumRows];
  logic                           carryTab [NumRows];
  logic                           zeroTab [NumRows];
  logic                           ovfTab [NumRows];
  int                             fillIdx;

  logic [aluOpPkg::CmdWidth-1:0]  expCommand;
  logic [aluOpPkg::DataWidth-1:0] expResult;
  logic                           expCarryout;
  logic                           expZero;
  logic                           expOverflow;
  logic                           endOfTest;
  int                             rowsDone;
  int                             errorCount;
  logic                           reportDone;
  int                             tbErrors;
  integer                         seed;

  // row the checker expects next
  assign expCommand  = cmdTab[rowsDone];
  assign expResult   = resTab[rowsDone];
  assign expCarryout = carryTab[rowsDone];
  assign expZero     = zeroTab[rowsDone];
  assign expOverflow = ovfTab[rowsDone];

  pipelinedAlu u_pipelinedAlu (
    .clk(clk), .rstN(rstN),
    .opValid(opValid), .command(command), .operandA(operandA), .operandB(operandB),
    .opCredit(opCredit), .resValid(resValid), .result(result),
    .carryout(carryout), .zero(zero), .overflow(overflow), .resCredit(resCredit)
  );

  aluChecker #(.NumRows(NumRows)) u_aluChecker (
    .clk(clk), .rstN(rstN), .opValid(opValid), .opCredit(opCredit),
    .resValid(resValid), .result(result), .carryout(carryout), .zero(zero),
    .overflow(overflow), .resCredit(resCredit),
    .expCommand(expCommand), .expResult(expResult), .expCarryout(expCarryout),
    .expZero(expZero), .expOverflow(expOverflow), .endOfTest(endOfTest),
    .rowsDone(rowsDone), .errorCount(errorCount), .reportDone(reportDone)
  );

  task automatic addRow(input logic [aluOpPkg::CmdWidth-1:0] cmd,
                        input logic [aluOpPkg::DataWidth-1:0] a,
                        input logic [aluOpPkg::DataWidth-1:0] b,
                        input logic [aluOpPkg::DataWidth-1:0] res,
                        input logic c,
                        input logic z,
                        input logic v);
    cmdTab[fillIdx]   = cmd;
    aTab[fillIdx]     = a;
    bTab[fillIdx]     = b;
    resTab[fillIdx]   = res;
    carryTab[fillIdx] = c;
    zeroTab[fillIdx]  = z;
    ovfTab[fillIdx]   = v;
    fillIdx++;
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin : fillTable
    $timeformat(-9, 1, " ns", 0);
    fillIdx = 0;
    addRow(aluOpPkg::CmdAdd, 32'h0000_0005, 32'h0000_0007, 32'h0000_000c, 1'b0, 1'b0, 1'b0);
    addRow(aluOpPkg::CmdAdd, 32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000, 1'b0, 1'b0, 1'b1);
    addRow(aluOpPkg::CmdAdd, 32'h8000_0000, 32'h8000_0000, 32'h0000_0000, 1'b1, 1'b1, 1'b1);
    addRow(aluOpPkg::CmdAdd, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 1'b1, 1'b1, 1'b0);
    addRow(aluOpPkg::CmdSub, 32'h1234_5678, 32'h1234_5678, 32'h0000_0000, 1'b1, 1'b1, 1'b0);
    addRow(aluOpPkg::CmdSub, 32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 1'b0, 1'b0, 1'b0);
    addRow(aluOpPkg::CmdSub, 32'h0000_000a, 32'h0000_0003, 32'h0000_0007, 1'b1, 1'b0, 1'b0);
    addRow(aluOpPkg::CmdSub, 32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff, 1'b1, 1'b0, 1'b1);
    addRow(aluOpPkg::CmdAdd, 32'hffff_fff0, 32'hffff_fff0, 32'hffff_ffe0, 1'b1, 1'b0, 1'b0);
    // the last three slt rows overflow inside the subtraction
    addRow(aluOpPkg::CmdSlt, 32'h0000_0003, 32'h0000_0005, 32'h0000_0001, 1'b0, 1'b0, 1'b0);
    addRow(aluOpPkg::CmdSlt, 32'h0000_0005, 32'h0000_0003, 32'h0000_0000, 1'b0, 1'b0, 1'b0);
    addRow(aluOpPkg::CmdSlt, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0001, 1'b0, 1'b0, 1'b0);
    addRow(aluOpPkg::CmdSlt, 32'h0000_0007, 32'h0000_0007, 32'h0000_0000, 1'b0, 1'b0, 1'b0);
    addRow(aluOpPkg::CmdSlt, 32'h8000_0000, 32'h0000_0001, 32'h0000_0001, 1'b0, 1'b0, 1'b0);
    addRow(aluOpPkg::CmdSlt, 32'h7fff_ffff, 32'hffff_ffff, 32'h0000_0000, 1'b0, 1'b0, 1'b0);
    addRow(aluOpPkg::CmdSlt, 32'h8000_0000, 32'h7fff_ffff, 32'h0000_0001, 1'b0, 1'b0, 1'b0);
    addRow(aluOpPkg::CmdXor, 32'hf0f0_f0f0, 32'hff00_ff00, 32'h0ff0_0ff0, 1'b0, 1'b0, 1'b0);
    addRow(aluOpPkg::CmdAnd, 32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000, 1'b0, 1'b0, 1'b0);
    addRow(aluOpPkg::CmdNand, 32'hf0f0_f0f0, 32'hff00_ff00, 32'h0fff_0fff, 1'b0, 1'b0, 1'b0);
    addRow(aluOpPkg::CmdOr, 32'hf0f0_f0f0, 32'hff00_ff00, 32'hfff0_fff0, 1'b0, 1'b0, 1'b0);
    addRow(aluOpPkg::CmdNor, 32'hf0f0_f0f0, 32'hff00_ff00, 32'h000f_000f, 1'b0, 1'b0, 1'b0);
    addRow(aluOpPkg::CmdXor, 32'h1234_5678, 32'h1234_5678, 32'h0000_0000, 1'b0, 1'b0, 1'b0);
    addRow(aluOpPkg::CmdAnd, 32'haaaa_aaaa, 32'h5555_5555, 32'h0000_0000, 1'b0, 1'b0, 1'b0);
    addRow(aluOpPkg::CmdOr, 32'haaaa_aaaa, 32'h5555_5555, 32'hffff_ffff, 1'b0, 1'b0, 1'b0);
  end

  initial begin : mainSeq
    rstN      = 1'b0;
    endOfTest = 1'b0;
    repeat (8) @(posedge clk);
    rstN <= 1'b1;
    wait (rowsDone == NumRows);
    repeat (DrainCycles) @(posedge clk);
    endOfTest <= 1'b1;
    wait (reportDone === 1'b1);
    if (errorCount == 0 && tbErrors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // producer sends the next row whenever it holds an input credit
  initial begin : producer
    int credits;
    int opsSent;
    credits  = aluFlowPkg::QueueDepth;
    opsSent  = 0;
    tbErrors = 0;
    opValid  = 1'b0;
    command  = '0;
    operandA = '0;
    operandB = '0;
    wait (rstN === 1'b1);
    forever begin
      @(posedge clk);
      if (opCredit === 1'b1) begin
        credits++;
        if (credits > aluFlowPkg::QueueDepth) begin
          $display("more input credits came back than ops were outstanding, at %0t", $time);
          tbErrors++;
        end
      end
      if (opsSent < NumRows && credits > 0) begin
        opValid  <= 1'b1;
        command  <= cmdTab[opsSent];
        operandA <= aTab[opsSent];
        operandB <= bTab[opsSent];
        credits--;
        opsSent++;
      end else begin
        opValid <= 1'b0;
      end
    end
  end

  // consumer frees each slot after a random delay
  initial begin : consumer
    int dueCycle[$];
    int cycle;
    int received;
    int holdUntil;
    logic holdDone;
    cycle     = 0;
    received  = 0;
    holdUntil = 0;
    holdDone  = 1'b0;
    seed      = 32'h23e;
    resCredit = 1'b0;
    wait (rstN === 1'b1);
    forever begin
      @(posedge clk);
      cycle++;
      if (resValid === 1'b1) begin
        received++;
        dueCycle.push_back(cycle + ($unsigned($random(seed)) % 8));
        if (received == HoldAfter && !holdDone) begin
          holdUntil = cycle + HoldCycles; // withhold every credit for a while
          holdDone  = 1'b1;
        end
      end
      if (cycle >= holdUntil && dueCycle.size() > 0 && dueCycle[0] <= cycle) begin
        resCredit <= 1'b1;
        void'(dueCycle.pop_front());
      end else begin
        resCredit <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (TimeoutCycles) @(posedge clk);
    $display("timeout after %0d cycles: only %0d of %0d results arrived, results went missing",
             TimeoutCycles, rowsDone, NumRows);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* flist.f */
source/aluOpPkg.sv
source/aluFlowPkg.sv
source/aluDecode.sv
source/aluExecute.sv
source/resultQueue.sv
source/pipelinedAlu.sv
verification/aluChecker.sv
verification/pipelinedAluTb.sv
